//--- armCore.f
rtl/armPkg.sv
rtl/alu.sv
rtl/regFile.sv
rtl/datapath.sv
rtl/controlDecoder.sv
rtl/condUnit.sv
rtl/armCore.sv
sim/armCore_props.sv
sim/armCore_tb.sv

//--- rtl/alu.sv
`timescale 1ns/1ps

module alu (
   input  logic [armPkg::dataWidth-1:0] a,
   input  logic [armPkg::dataWidth-1:0] b,
   input  armPkg::aluOpT                aluControl,
   output logic [armPkg::dataWidth-1:0] result,
   output logic [3:0]                   flags
);

   logic                         isSub;
   logic                         isArith;
   logic [armPkg::dataWidth-1:0] bInv;
   logic [armPkg::dataWidth:0]   sum;    // Extra bit holds carry out

   assign isSub   = (aluControl == armPkg::aluSub);
   assign isArith = (aluControl == armPkg::aluAdd) || isSub;
   assign bInv    = isSub ? ~b : b;
   assign sum     = {1'b0, a} + {1'b0, bInv} + {{armPkg::dataWidth{1'b0}}, isSub};

   always_comb begin
      case (aluControl)
         armPkg::aluAdd,
         armPkg::aluSub: result = sum[armPkg::dataWidth-1:0];
         armPkg::aluAnd: result = a & b;
         default:        result = a | b;    // ORR
      endcase
   end

   assign flags[armPkg::flagN] = result[armPkg::dataWidth-1];
   assign flags[armPkg::flagZ] = (result == '0);
   assign flags[armPkg::flagC] = isArith & sum[armPkg::dataWidth];
   // Overflow when operand signs agree and the sum sign differs
   assign flags[armPkg::flagV] = isArith
                                 & ~(a[armPkg::dataWidth-1] ^ b[armPkg::dataWidth-1] ^ isSub)
                                 & (a[armPkg::dataWidth-1] ^ sum[armPkg::dataWidth-1]);

endmodule

//--- rtl/armCore.sv
`timescale 1ns/1ps

module armCore (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [armPkg::dataWidth-1:0] instr,
   input  logic [armPkg::dataWidth-1:0] readData,
   input  logic                         pcReady,
   output logic [armPkg::dataWidth-1:0] pc,
   output logic                         memWrite,
   output logic [armPkg::dataWidth-1:0] aluResult,
   output logic [armPkg::dataWidth-1:0] writeData
);

   logic [3:0]     aluFlags;
   logic [1:0]     flagW;
   logic           pcs;
   logic           regW;
   logic           memW;
   logic           memToReg;
   logic           aluSrc;
   armPkg::immSrcT immSrc;
   logic [1:0]     regSrc;
   armPkg::aluOpT  aluControl;
   logic           regWrite;
   logic           pcSrc;

   controlDecoder decoder_i (
      .instr      (instr),
      .flagW      (flagW),
      .pcs        (pcs),
      .regW       (regW),
      .memW       (memW),
      .memToReg   (memToReg),
      .aluSrc     (aluSrc),
      .immSrc     (immSrc),
      .regSrc     (regSrc),
      .aluControl (aluControl)
   );

   condUnit condUnit_i (
      .clk      (clk),
      .reset    (reset),
      .cond     (armPkg::condT'(instr[armPkg::condMsb:armPkg::condLsb])),
      .aluFlags (aluFlags),
      .flagW    (flagW),
      .pcs      (pcs),
      .regW     (regW),
      .memW     (memW),
      .pcReady  (pcReady),
      .pcSrc    (pcSrc),
      .regWrite (regWrite),
      .memWrite (memWrite)
   );

   datapath datapath_i (
      .clk        (clk),
      .reset      (reset),
      .regSrc     (regSrc),
      .regWrite   (regWrite),
      .immSrc     (immSrc),
      .aluSrc     (aluSrc),
      .aluControl (aluControl),
      .memToReg   (memToReg),
      .pcSrc      (pcSrc),
      .pcReady    (pcReady),
      .instr      (instr),
      .readData   (readData),
      .aluFlags   (aluFlags),
      .pc         (pc),
      .aluResult  (aluResult),
      .writeData  (writeData)
   );

endmodule

//--- rtl/armPkg.sv
package armPkg;

   localparam int dataWidth    = 32;
   localparam int regAddrWidth = 4;

   localparam logic [regAddrWidth-1:0] pcRegIdx = 4'd15;    // r15 reads as PC+8
   localparam logic [dataWidth-1:0]    pcStep   = 32'd4;    // Bytes per instruction

   // Op field encodings
   localparam logic [1:0] opDataProc = 2'b00;
   localparam logic [1:0] opMemory   = 2'b01;
   localparam logic [1:0] opBranch   = 2'b10;

   // Command field of data-processing instructions
   localparam logic [3:0] functAdd = 4'b0100;
   localparam logic [3:0] functSub = 4'b0010;
   localparam logic [3:0] functAnd = 4'b0000;
   localparam logic [3:0] functOrr = 4'b1100;

   typedef enum logic [1:0] {aluAdd, aluSub, aluAnd, aluOrr} aluOpT;

   typedef enum logic [1:0] {immByte, immOffset, immBranch} immSrcT;

   typedef enum logic [3:0] {
      condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
      condHi, condLs, condGe, condLt, condGt, condLe, condAl, condNv
   } condT;

   // Bit positions in a NZCV vector
   localparam int flagN = 3;
   localparam int flagZ = 2;
   localparam int flagC = 1;
   localparam int flagV = 0;

   // Instruction field positions
   localparam int condMsb  = 31;
   localparam int condLsb  = 28;
   localparam int opMsb    = 27;
   localparam int opLsb    = 26;
   localparam int functMsb = 25;
   localparam int functLsb = 20;
   localparam int rnMsb    = 19;
   localparam int rnLsb    = 16;
   localparam int rdMsb    = 15;
   localparam int rdLsb    = 12;
   localparam int rmMsb    = 3;
   localparam int rmLsb    = 0;

endpackage

//--- rtl/condUnit.sv
`timescale 1ns/1ps

module condUnit (
   input  logic         clk,
   input  logic         reset,
   input  armPkg::condT cond,
   input  logic [3:0]   aluFlags,
   input  logic [1:0]   flagW,
   input  logic         pcs,
   input  logic         regW,
   input  logic         memW,
   input  logic         pcReady,
   output logic         pcSrc,
   output logic         regWrite,
   output logic         memWrite
);

   logic [3:0] flags;
   logic [1:0] flagWrite;
   logic       condEx;
   logic       commit;
   logic       n, z, c, v;
   logic       ge;

   // N/Z pair and C/V pair update independently
   always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
         flags <= 4'b0000;
      end else begin
         if (flagWrite[1]) begin
            flags[armPkg::flagN] <= aluFlags[armPkg::flagN];
            flags[armPkg::flagZ] <= aluFlags[armPkg::flagZ];
         end
         if (flagWrite[0]) begin
            flags[armPkg::flagC] <= aluFlags[armPkg::flagC];
            flags[armPkg::flagV] <= aluFlags[armPkg::flagV];
         end
      end
   end

   assign n  = flags[armPkg::flagN];
   assign z  = flags[armPkg::flagZ];
   assign c  = flags[armPkg::flagC];
   assign v  = flags[armPkg::flagV];
   assign ge = (n == v);

   always_comb begin
      case (cond)
         armPkg::condEq: condEx = z;
         armPkg::condNe: condEx = ~z;
         armPkg::condCs: condEx = c;
         armPkg::condCc: condEx = ~c;
         armPkg::condMi: condEx = n;
         armPkg::condPl: condEx = ~n;
         armPkg::condVs: condEx = v;
         armPkg::condVc: condEx = ~v;
         armPkg::condHi: condEx = c & ~z;
         armPkg::condLs: condEx = ~c | z;
         armPkg::condGe: condEx = ge;
         armPkg::condLt: condEx = ~ge;
         armPkg::condGt: condEx = ~z & ge;
         armPkg::condLe: condEx = z | ~ge;
         armPkg::condAl: condEx = 1'b1;
         armPkg::condNv: condEx = 1'b0;
      endcase
   end

   // A stalled cycle commits nothing
   assign commit    = condEx & pcReady;
   assign flagWrite = flagW & {2{commit}};
   assign regWrite  = regW & commit;
   assign memWrite  = memW & commit;
   assign pcSrc     = pcs & condEx;    // PC register itself holds on stall

endmodule

//--- rtl/controlDecoder.sv
`timescale 1ns/1ps

module controlDecoder (
   input  logic [armPkg::dataWidth-1:0] instr,
   output logic [1:0]                   flagW,
   output logic                         pcs,
   output logic                         regW,
   output logic                         memW,
   output logic                         memToReg,
   output logic                         aluSrc,
   output armPkg::immSrcT               immSrc,
   output logic [1:0]                   regSrc,
   output armPkg::aluOpT                aluControl
);

   logic [1:0]                      op;
   logic [5:0]                      funct;
   logic [3:0]                      cmd;
   logic [armPkg::regAddrWidth-1:0] rd;
   logic                            sBit;
   logic                            branch;
   logic                            aluOp;
   logic                            isArith;
   armPkg::aluOpT                   cmdOp;

   assign op    = instr[armPkg::opMsb:armPkg::opLsb];
   assign funct = instr[armPkg::functMsb:armPkg::functLsb];
   assign rd    = instr[armPkg::rdMsb:armPkg::rdLsb];
   assign cmd   = funct[4:1];
   assign sBit  = funct[0];    // S bit, or L bit for memory ops

   // Main decoder
   always_comb begin
      regSrc   = 2'b00;
      immSrc   = armPkg::immByte;
      aluSrc   = 1'b0;
      memToReg = 1'b0;
      regW     = 1'b0;
      memW     = 1'b0;
      branch   = 1'b0;
      aluOp    = 1'b0;
      case (op)
         armPkg::opDataProc: begin
            aluSrc = funct[5];    // Immediate form takes imm8
            regW   = 1'b1;
            aluOp  = 1'b1;
         end
         armPkg::opMemory: begin
            immSrc = armPkg::immOffset;
            aluSrc = 1'b1;
            if (funct[0]) begin    // LDR
               regW     = 1'b1;
               memToReg = 1'b1;
            end else begin    // STR reads Rd on port 2
               memW   = 1'b1;
               regSrc = 2'b10;
            end
         end
         armPkg::opBranch: begin
            regSrc = 2'b01;    // Base is r15
            immSrc = armPkg::immBranch;
            aluSrc = 1'b1;
            branch = 1'b1;
         end
         default: ;
      endcase
   end

   // ALU decoder
   always_comb begin
      case (cmd)
         armPkg::functSub: cmdOp = armPkg::aluSub;
         armPkg::functAnd: cmdOp = armPkg::aluAnd;
         armPkg::functOrr: cmdOp = armPkg::aluOrr;
         default:          cmdOp = armPkg::aluAdd;
      endcase
   end

   assign isArith    = (cmd == armPkg::functAdd) || (cmd == armPkg::functSub);
   assign aluControl = aluOp ? cmdOp : armPkg::aluAdd;
   assign flagW      = aluOp ? {sBit, sBit & isArith} : 2'b00;    // C/V only for ADD/SUB

   assign pcs = ((rd == armPkg::pcRegIdx) && regW) || branch;

endmodule

//--- rtl/datapath.sv
`timescale 1ns/1ps

module datapath (
   input  logic                         clk,
   input  logic                         reset,
   input  logic [1:0]                   regSrc,
   input  logic                         regWrite,
   input  armPkg::immSrcT               immSrc,
   input  logic                         aluSrc,
   input  armPkg::aluOpT                aluControl,
   input  logic                         memToReg,
   input  logic                         pcSrc,
   input  logic                         pcReady,
   input  logic [armPkg::dataWidth-1:0] instr,
   input  logic [armPkg::dataWidth-1:0] readData,
   output logic [3:0]                   aluFlags,
   output logic [armPkg::dataWidth-1:0] pc,
   output logic [armPkg::dataWidth-1:0] aluResult,
   output logic [armPkg::dataWidth-1:0] writeData
);

   logic [armPkg::dataWidth-1:0]    pcNext;
   logic [armPkg::dataWidth-1:0]    pcPlus4;
   logic [armPkg::dataWidth-1:0]    pcPlus8;
   logic [armPkg::dataWidth-1:0]    extImm;
   logic [armPkg::dataWidth-1:0]    srcA;
   logic [armPkg::dataWidth-1:0]    srcB;
   logic [armPkg::dataWidth-1:0]    result;
   logic [armPkg::regAddrWidth-1:0] readAddr1;
   logic [armPkg::regAddrWidth-1:0] readAddr2;

   always_ff @(posedge clk or posedge reset) begin
      if (reset)
         pc <= '0;
      else if (pcReady)
         pc <= pcNext;
   end

   assign pcPlus4 = pc + armPkg::pcStep;
   assign pcPlus8 = pcPlus4 + armPkg::pcStep;
   assign pcNext  = pcSrc ? result : pcPlus4;    // Branch or write to r15

   assign readAddr1 = regSrc[0] ? armPkg::pcRegIdx : instr[armPkg::rnMsb:armPkg::rnLsb];
   assign readAddr2 = regSrc[1] ? instr[armPkg::rdMsb:armPkg::rdLsb]
                                : instr[armPkg::rmMsb:armPkg::rmLsb];

   regFile regFile_i (
      .clk         (clk),
      .writeEnable (regWrite),
      .readAddr1   (readAddr1),
      .readAddr2   (readAddr2),
      .writeAddr   (instr[armPkg::rdMsb:armPkg::rdLsb]),
      .writeData   (result),
      .pcPlus8     (pcPlus8),
      .readData1   (srcA),
      .readData2   (writeData)
   );

   // Immediate extension
   always_comb begin
      case (immSrc)
         armPkg::immByte:   extImm = {{(armPkg::dataWidth-8){1'b0}}, instr[7:0]};
         armPkg::immOffset: extImm = {{(armPkg::dataWidth-12){1'b0}}, instr[11:0]};
         armPkg::immBranch: extImm = {{(armPkg::dataWidth-26){instr[23]}}, instr[23:0], 2'b00};
         default:           extImm = '0;
      endcase
   end

   assign srcB = aluSrc ? extImm : writeData;

   alu alu_i (
      .a          (srcA),
      .b          (srcB),
      .aluControl (aluControl),
      .result     (aluResult),
      .flags      (aluFlags)
   );

   assign result = memToReg ? readData : aluResult;    // LDR writes back memory data

endmodule

//--- rtl/regFile.sv
`timescale 1ns/1ps

module regFile (
   input  logic                            clk,
   input  logic                            writeEnable,
   input  logic [armPkg::regAddrWidth-1:0] readAddr1,
   input  logic [armPkg::regAddrWidth-1:0] readAddr2,
   input  logic [armPkg::regAddrWidth-1:0] writeAddr,
   input  logic [armPkg::dataWidth-1:0]    writeData,
   input  logic [armPkg::dataWidth-1:0]    pcPlus8,
   output logic [armPkg::dataWidth-1:0]    readData1,
   output logic [armPkg::dataWidth-1:0]    readData2
);

   // r0 to r14 only
   logic [armPkg::dataWidth-1:0] regs [0:armPkg::pcRegIdx-1];

   always_ff @(posedge clk) begin
      if (writeEnable && (writeAddr != armPkg::pcRegIdx))    // r15 goes to the PC instead
         regs[writeAddr] <= writeData;
   end

   assign readData1 = (readAddr1 == armPkg::pcRegIdx) ? pcPlus8 : regs[readAddr1];
   assign readData2 = (readAddr2 == armPkg::pcRegIdx) ? pcPlus8 : regs[readAddr2];

endmodule

//--- run.sh
#!/bin/sh
# Build and run the armCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module armCore_tb -Mdir obj_dir -f armCore.f
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

output=$(./obj_dir/VarmCore_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if printf '%s\n' "$output" | grep -q "^Simulation finished: PASS$"; then
   exit 0
fi
echo "Pass message not found"
exit 1

//--- sim/armCore_props.sv
`timescale 1ns/1ps

module armCoreProps (
   input logic                         clk,
   input logic                         reset,
   input logic                         pcReady,
   input logic                         memWrite,
   input logic [armPkg::dataWidth-1:0] pc
);

   // A stalled edge leaves the PC where it was
   assert property (@(posedge clk) disable iff (reset) !pcReady |=> $stable(pc))
      else $error("PC changed across an edge with pcReady low");

   assert property (@(posedge clk) !pcReady |-> !memWrite)
      else $error("memWrite high while pcReady is low");

   assert property (@(posedge clk) pc[1:0] == 2'b00)
      else $error("PC is not word-aligned");

   assert property (@(posedge clk) $fell(reset) |-> (pc == '0))
      else $error("PC is not zero in the first cycle after reset");

endmodule

bind armCore armCoreProps props_i (
   .clk      (clk),
   .reset    (reset),
   .pcReady  (pcReady),
   .memWrite (memWrite),
   .pc       (pc)
);

//--- sim/armCore_tb.sv
`timescale 1ns/1ps

module armCore_tb;

   typedef struct {
      string       name;
      logic [31:0] instr;
      logic [31:0] readData;
      logic        pcReady;
      logic [31:0] expAlu;
      logic        expMemWrite;
      logic [31:0] expWriteData;    // Compared only when a store writes
      logic [31:0] expPc;           // PC after the next rising edge
   } rowT;

   logic        clk;
   logic        reset;
   logic [31:0] instr;
   logic [31:0] readData;
   logic        pcReady;
   logic [31:0] pc;
   logic        memWrite;
   logic [31:0] aluResult;
   logic [31:0] writeData;

   rowT         rows[$];
   logic [31:0] curPc;
   logic [31:0] d1;
   logic [31:0] d2;
   logic [31:0] d3;
   logic [31:0] d4;
   integer      seed;
   int          errorCount;
   int          checkCount;
   logic        tableBuilt;

   armCore dut_i (
      .clk       (clk),
      .reset     (reset),
      .instr     (instr),
      .readData  (readData),
      .pcReady   (pcReady),
      .pc        (pc),
      .memWrite  (memWrite),
      .aluResult (aluResult),
      .writeData (writeData)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Instruction encoders take operands in assembly order
   function automatic logic [31:0] dpImm(input logic [3:0] cmd, input logic s,
         input logic [3:0] rd, input logic [3:0] rn, input logic [7:0] imm8);
      return {armPkg::condAl, armPkg::opDataProc, 1'b1, cmd, s, rn, rd, 4'h0, imm8};
   endfunction

   function automatic logic [31:0] dpReg(input logic [3:0] cmd, input logic s,
         input logic [3:0] rd, input logic [3:0] rn, input logic [3:0] rm);
      return {armPkg::condAl, armPkg::opDataProc, 1'b0, cmd, s, rn, rd, 8'h00, rm};
   endfunction

   function automatic logic [31:0] memOp(input logic load, input logic [3:0] rd,
         input logic [3:0] rn, input logic [11:0] imm12);
      return {armPkg::condAl, armPkg::opMemory, 5'b01100, load, rn, rd, imm12};
   endfunction

   function automatic logic [31:0] branchOp(input logic [23:0] imm24);
      return {armPkg::condAl, armPkg::opBranch, 2'b10, imm24};
   endfunction

   function automatic logic [31:0] onCond(input armPkg::condT cond, input logic [31:0] ins);
      return {cond, ins[27:0]};
   endfunction

   task automatic pushRow(input string name, input logic [31:0] ins, input logic [31:0] rd,
         input logic rdy, input logic [31:0] alu, input logic mw, input logic [31:0] wd,
         input logic [31:0] nextPc);
      rowT row;
      row = '{name, ins, rd, rdy, alu, mw, wd, nextPc};
      rows.push_back(row);
      curPc = nextPc;
   endtask

   task automatic execRow(input string name, input logic [31:0] ins, input logic [31:0] rd,
         input logic [31:0] alu);
      pushRow(name, ins, rd, 1'b1, alu, 1'b0, 32'h0, curPc + 32'd4);
   endtask

   task automatic storeRow(input string name, input logic [31:0] ins, input logic [31:0] alu,
         input logic mw, input logic [31:0] wd);
      pushRow(name, ins, 32'h0, 1'b1, alu, mw, wd, curPc + 32'd4);
   endtask

   task automatic jumpRow(input string name, input logic [31:0] ins, input logic [31:0] alu,
         input logic [31:0] nextPc);
      pushRow(name, ins, 32'h0, 1'b1, alu, 1'b0, 32'h0, nextPc);
   endtask

   task automatic stallRow(input string name, input logic [31:0] ins, input logic [31:0] alu);
      pushRow(name, ins, 32'h0, 1'b0, alu, 1'b0, 32'h0, curPc);
   endtask

   task automatic compareValue(input string name, input logic [31:0] expected,
         input logic [31:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errorCount++;
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
      end
   endtask

   task automatic buildTable();
      seed  = 32'h886d_3476;
      d1    = $random(seed);
      d2    = $random(seed);
      d3    = $random(seed);
      d4    = $random(seed);
      curPc = 32'h0;
      // Load bases r5 = 8 and r6 = 12 before r1 to r4 from random data
      execRow("ldr r5", memOp(1'b1, 4'd5, 4'd15, 12'h010), 32'h8, curPc + 32'd8 + 32'h10);
      execRow("ldr r6", memOp(1'b1, 4'd6, 4'd15, 12'h014), 32'hC, curPc + 32'd8 + 32'h14);
      execRow("ldr r1", memOp(1'b1, 4'd1, 4'd5, 12'h030), d1, 32'h38);
      execRow("ldr r2", memOp(1'b1, 4'd2, 4'd5, 12'h034), d2, 32'h3C);
      execRow("ldr r3", memOp(1'b1, 4'd3, 4'd6, 12'h038), d3, 32'h44);
      execRow("ldr r4", memOp(1'b1, 4'd4, 4'd15, 12'h03C), d4, curPc + 32'd8 + 32'h3C);
      execRow("add reg", dpReg(armPkg::functAdd, 1'b0, 4'd7, 4'd1, 4'd2), 32'h0, d1 + d2);
      execRow("add imm", dpImm(armPkg::functAdd, 1'b0, 4'd8, 4'd3, 8'h55), 32'h0, d3 + 32'h55);
      execRow("sub reg", dpReg(armPkg::functSub, 1'b0, 4'd9, 4'd1, 4'd3), 32'h0, d1 - d3);
      execRow("sub imm", dpImm(armPkg::functSub, 1'b0, 4'd10, 4'd4, 8'h0F), 32'h0, d4 - 32'h0F);
      execRow("and reg", dpReg(armPkg::functAnd, 1'b0, 4'd11, 4'd1, 4'd2), 32'h0, d1 & d2);
      execRow("and imm", dpImm(armPkg::functAnd, 1'b0, 4'd12, 4'd3, 8'hF0), 32'h0, d3 & 32'hF0);
      execRow("orr reg", dpReg(armPkg::functOrr, 1'b0, 4'd13, 4'd2, 4'd4), 32'h0, d2 | d4);
      execRow("orr imm", dpImm(armPkg::functOrr, 1'b0, 4'd14, 4'd4, 8'h3C), 32'h0, d4 | 32'h3C);
      storeRow("str r7", memOp(1'b0, 4'd7, 4'd5, 12'h100), 32'h108, 1'b1, d1 + d2);
      storeRow("str r8", memOp(1'b0, 4'd8, 4'd5, 12'h104), 32'h10C, 1'b1, d3 + 32'h55);
      storeRow("str r9", memOp(1'b0, 4'd9, 4'd5, 12'h108), 32'h110, 1'b1, d1 - d3);
      storeRow("str r10", memOp(1'b0, 4'd10, 4'd5, 12'h10C), 32'h114, 1'b1, d4 - 32'h0F);
      storeRow("str r11", memOp(1'b0, 4'd11, 4'd5, 12'h110), 32'h118, 1'b1, d1 & d2);
      storeRow("str r12", memOp(1'b0, 4'd12, 4'd5, 12'h114), 32'h11C, 1'b1, d3 & 32'hF0);
      storeRow("str r13", memOp(1'b0, 4'd13, 4'd5, 12'h118), 32'h120, 1'b1, d2 | d4);
      storeRow("str r14", memOp(1'b0, 4'd14, 4'd5, 12'h11C), 32'h124, 1'b1, d4 | 32'h3C);
      // Sets Z and C
      execRow("subs equal", dpReg(armPkg::functSub, 1'b1, 4'd0, 4'd1, 4'd1), 32'h0, 32'h0);
      storeRow("streq taken", onCond(armPkg::condEq, memOp(1'b0, 4'd1, 4'd5, 12'h200)),
               32'h208, 1'b1, d1);
      storeRow("strne skipped", onCond(armPkg::condNe, memOp(1'b0, 4'd1, 4'd5, 12'h204)),
               32'h20C, 1'b0, d1);
      execRow("add no s", dpReg(armPkg::functAdd, 1'b0, 4'd0, 4'd5, 4'd6), 32'h0, 32'd20);
      storeRow("streq kept z", onCond(armPkg::condEq, memOp(1'b0, 4'd2, 4'd5, 12'h208)),
               32'h210, 1'b1, d2);
      // 8 - 12 sets N and clears Z, C and V
      execRow("subs 8-12", dpReg(armPkg::functSub, 1'b1, 4'd0, 4'd5, 4'd6), 32'h0, 32'hFFFF_FFFC);
      storeRow("strge", onCond(armPkg::condGe, memOp(1'b0, 4'd1, 4'd5, 12'h20C)),
               32'h214, 1'b0, d1);
      storeRow("strlt", onCond(armPkg::condLt, memOp(1'b0, 4'd1, 4'd5, 12'h210)),
               32'h218, 1'b1, d1);
      storeRow("strhi", onCond(armPkg::condHi, memOp(1'b0, 4'd1, 4'd5, 12'h214)),
               32'h21C, 1'b0, d1);
      storeRow("strls", onCond(armPkg::condLs, memOp(1'b0, 4'd1, 4'd5, 12'h218)),
               32'h220, 1'b1, d1);
      // r0 holds -4, so an add of these operands would carry out
      execRow("ands", dpReg(armPkg::functAnd, 1'b1, 4'd0, 4'd0, 4'd6), 32'h0, 32'hC);
      storeRow("strcc after ands", onCond(armPkg::condCc, memOp(1'b0, 4'd2, 4'd5, 12'h21C)),
               32'h224, 1'b1, d2);
      storeRow("strvs after ands", onCond(armPkg::condVs, memOp(1'b0, 4'd2, 4'd5, 12'h220)),
               32'h228, 1'b0, d2);
      storeRow("strpl after ands", onCond(armPkg::condPl, memOp(1'b0, 4'd2, 4'd5, 12'h224)),
               32'h22C, 1'b1, d2);
      jumpRow("b taken", branchOp(24'h000003), curPc + 32'd8 + 32'd12, curPc + 32'd8 + 32'd12);
      jumpRow("beq skipped", onCond(armPkg::condEq, branchOp(24'hFFFFFC)),
              curPc + 32'd8 - 32'd16, curPc + 32'd4);
      jumpRow("add to r15", dpImm(armPkg::functAdd, 1'b0, 4'd15, 4'd5, 8'h78), 32'h80, 32'h80);
      stallRow("stall add", dpImm(armPkg::functAdd, 1'b0, 4'd7, 4'd5, 8'h01), 32'h9);
      stallRow("stall str", memOp(1'b0, 4'd7, 4'd5, 12'h000), 32'h8);
      storeRow("str after stall", memOp(1'b0, 4'd7, 4'd5, 12'h000), 32'h8, 1'b1, d1 + d2);
   endtask

   initial begin
      errorCount = 0;
      checkCount = 0;
      tableBuilt = 1'b0;
      reset      = 1'b1;
      pcReady    = 1'b0;
      readData   = 32'h0;
      instr      = {armPkg::condNv, 28'h0};    // AND that never executes
      buildTable();
      tableBuilt = 1'b1;
      repeat (3) @(negedge clk);
      reset = 1'b0;
      #15;
      compareValue("reset pc", 32'h0, pc);
      compareValue("reset memWrite", 32'h0, {31'b0, memWrite});
      @(negedge clk);
      compareValue("stall after reset pc", 32'h0, pc);
      foreach (rows[i]) begin
         instr    = rows[i].instr;
         readData = rows[i].readData;
         pcReady  = rows[i].pcReady;
         #15;    // Just before the rising edge
         compareValue({rows[i].name, " aluResult"}, rows[i].expAlu, aluResult);
         compareValue({rows[i].name, " memWrite"}, {31'b0, rows[i].expMemWrite},
                      {31'b0, memWrite});
         if (rows[i].expMemWrite)
            compareValue({rows[i].name, " writeData"}, rows[i].expWriteData, writeData);
         @(negedge clk);
         compareValue({rows[i].name, " pc"}, rows[i].expPc, pc);
      end
      $display("Checks: %0d, errors: %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

   // Watchdog
   initial begin
      int limitNs;
      wait (tableBuilt);
      limitNs = (rows.size() + 10) * 40;
      #(limitNs);
      $display("Timeout: the stimulus table did not finish within %0d ns", limitNs);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule
